// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= text_console_tb
FILE_LIST ?= text_console.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) verification/text_model.svh
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/text_console.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_console import text_pkg::*; #(
	parameter int columns = 16,
	parameter int lines = 8
) (
	input wire clk,
	input wire rst,
	input wire cmd_valid,
	input wire cmd_e cmd,
	input wire cmd_param_u param,
	input wire [$clog2(lines)-1:0] cur_row,
	input wire [$clog2(columns)-1:0] cur_col,
	input wire [7:0] attr,
	input wire [$clog2(lines)-1:0] disp_row,
	output logic busy,
	output logic [columns*char_w-1:0] disp_line
);

	// edit port between controller and RAM
	logic [$clog2(lines)-1:0] ram_addr;
	logic ram_wren;
	logic [columns*char_w-1:0] ram_wdata, ram_rdata;

	text_control #(
		.columns(columns),
		.lines(lines)
	) control (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.param(param),
		.cur_row(cur_row),
		.cur_col(cur_col),
		.attr(attr),
		.ram_rdata(ram_rdata),
		.ram_addr(ram_addr),
		.ram_wren(ram_wren),
		.ram_wdata(ram_wdata),
		.busy(busy)
	);

	text_ram #(
		.columns(columns),
		.lines(lines)
	) ram (
		.clk(clk),
		.addr(ram_addr),
		.wren(ram_wren),
		.wdata(ram_wdata),
		.rdata(ram_rdata),
		.disp_row(disp_row),
		.disp_line(disp_line)
	);

endmodule

`default_nettype wire

// ==== logic/text_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_control import text_pkg::*; #(
	parameter int columns = 16,
	parameter int lines = 8
) (
	input wire clk,
	input wire rst,
	input wire cmd_valid,
	input wire cmd_e cmd,
	input wire cmd_param_u param,
	input wire [$clog2(lines)-1:0] cur_row,
	input wire [$clog2(columns)-1:0] cur_col,
	input wire [7:0] attr,
	input wire [columns*char_w-1:0] ram_rdata,
	output logic [$clog2(lines)-1:0] ram_addr,
	output logic ram_wren,
	output logic [columns*char_w-1:0] ram_wdata,
	output logic busy
);

	localparam int cw = $clog2(columns + 1); // index columns selects a blank
	localparam int rw = $clog2(lines + 1);
	localparam int ra = $clog2(lines);
	localparam int nw = 16; // count arithmetic
	localparam int lw = columns * char_w;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_lread = 3'd1;
	localparam logic [2:0] st_lwait = 3'd2;
	localparam logic [2:0] st_lmove = 3'd3;
	localparam logic [2:0] st_lwrite = 3'd4;
	localparam logic [2:0] st_sread = 3'd5;
	localparam logic [2:0] st_swrite = 3'd6;
	localparam logic [2:0] st_clear = 3'd7;

	logic [2:0] state, idle_next;

	// latched line edit
	logic ed_mode;
	logic ed_dir;
	logic [char_w-1:0] ed_data;
	logic [cw-1:0] ed_start, ed_end, col_now;
	logic [rw-1:0] ed_row;
	logic [lw-1:0] line_reg, move_line, set_line;
	logic [lw+char_w-1:0] src_line;
	logic [cw-1:0] next_col, next_read_col;

	// scroll and row clear
	logic sc_dir; // 1 moves rows down
	logic [rw-1:0] sc_row, sc_last, sc_step;
	logic [rw-1:0] clr_row, clr_bot;
	logic [rw-1:0] row_sel;

	// command decode
	logic [7:0] chr_code, cnt;
	logic [nw-1:0] col_room, col_cnt, row_room, row_cnt;
	logic [cw-1:0] cnt_end;

	assign chr_code = (param.chr == 8'h00) ? 8'h20 : param.chr;
	assign cnt = (param.num == 8'h00) ? 8'd1 : param.num;
	assign col_room = nw'(columns) - nw'(cur_col);
	assign col_cnt = (nw'(cnt) > col_room) ? col_room : nw'(cnt);
	assign row_room = nw'(lines) - nw'(cur_row);
	assign row_cnt = (nw'(cnt) > row_room) ? row_room : nw'(cnt);
	assign cnt_end = cw'(nw'(cur_col) + col_cnt - 1'b1); // last cell of a counted range

	assign src_line = {blank_cell, line_reg};
	assign busy = (state != st_idle);

	text_line_edit #(
		.columns(columns)
	) line_edit (
		.mode(ed_mode),
		.data(ed_data),
		.col_start(ed_start),
		.col_end(ed_end),
		.col_now(col_now),
		.move_dir(ed_dir),
		.cur_line(line_reg),
		.set_line(set_line),
		.next_col(next_col),
		.next_read_col(next_read_col)
	);

	always_comb
	begin
		case (cmd)
		cmd_input:
			idle_next = (chr_code >= 8'h20) ? st_lread : st_idle; // control codes dropped
		cmd_el, cmd_ech, cmd_ich, cmd_dch:
			idle_next = st_lread;
		cmd_ed:
			idle_next = st_clear;
		cmd_il, cmd_dl:
			idle_next = (row_cnt == row_room) ? st_clear : st_sread; // nothing left to copy
		default:
			idle_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= st_idle;
		else
		begin
			case (state)
			st_idle:
				if (cmd_valid)
					state <= idle_next;
			st_lread:
				state <= st_lwait;
			st_lwait:
				state <= ed_mode ? st_lmove : st_lwrite;
			st_lmove:
				if (next_col == (ed_dir ? cw'(columns - 1) : '0))
					state <= st_lwrite;
			st_lwrite:
				state <= st_idle;
			st_sread:
				state <= st_swrite;
			st_swrite:
				state <= (sc_row == sc_last) ? st_clear : st_sread;
			st_clear:
				if (clr_row == clr_bot)
					state <= st_idle;
			default:
				state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
		st_idle:
			if (cmd_valid)
			begin
				ed_mode <= 1'b0;
				ed_dir <= (cmd == cmd_dch);
				ed_data <= blank_cell;
				ed_row <= rw'(cur_row);
				ed_start <= cw'(cur_col);
				ed_end <= cnt_end;
				sc_dir <= (cmd == cmd_il);
				sc_step <= rw'(row_cnt);
				case (cmd)
				cmd_input:
				begin
					ed_data <= {attr, chr_code};
					ed_end <= cw'(cur_col);
				end
				cmd_el:
				begin
					ed_start <= (param.num != 8'd0) ? '0 : cw'(cur_col);
					ed_end <= (param.num != 8'd1) ? cw'(columns - 1) : cw'(cur_col);
				end
				cmd_ich, cmd_dch:
					ed_mode <= 1'b1;
				cmd_ed:
				begin
					clr_row <= (param.num != 8'd0) ? '0 : rw'(cur_row);
					clr_bot <= (param.num != 8'd1) ? rw'(lines - 1) : rw'(cur_row);
				end
				cmd_il:
				begin
					sc_row <= rw'(lines - 1); // copy from the bottom up
					sc_last <= rw'(nw'(cur_row) + row_cnt);
					clr_row <= rw'(cur_row);
					clr_bot <= rw'(nw'(cur_row) + row_cnt - 1'b1);
				end
				cmd_dl:
				begin
					sc_row <= rw'(cur_row);
					sc_last <= rw'(nw'(lines - 1) - row_cnt);
					clr_row <= rw'(nw'(lines) - row_cnt);
					clr_bot <= rw'(lines - 1);
				end
				default:
					;
				endcase
			end
		st_lwait:
		begin
			line_reg <= ram_rdata;
			col_now <= ed_dir ? '1 : cw'(columns); // one step before the first column
		end
		st_lmove:
		begin
			move_line[next_col*char_w +: char_w] <= src_line[next_read_col*char_w +: char_w];
			col_now <= next_col;
		end
		st_swrite:
			sc_row <= sc_dir ? sc_row - 1'b1 : sc_row + 1'b1;
		st_clear:
			clr_row <= clr_row + 1'b1;
		default:
			;
		endcase
	end

	always_comb
	begin
		row_sel = ed_row;
		ram_wren = 1'b0;
		ram_wdata = ed_mode ? move_line : set_line;
		case (state)
		st_lwrite:
			ram_wren = 1'b1;
		st_sread:
			row_sel = sc_dir ? sc_row - sc_step : sc_row + sc_step; // source row
		st_swrite:
		begin
			row_sel = sc_row;
			ram_wren = 1'b1;
			ram_wdata = ram_rdata;
		end
		st_clear:
		begin
			row_sel = clr_row;
			ram_wren = 1'b1;
			ram_wdata = {columns{blank_cell}};
		end
		default:
			;
		endcase
	end

	assign ram_addr = ra'(row_sel);

	assert property (@(posedge clk) disable iff (rst)
		ram_wren |-> ($past(busy) || $past(cmd_valid)))
		else $error("text RAM written out of idle without an accepted command");

	assert property (@(posedge clk) disable iff (rst) ram_wren |-> (row_sel < rw'(lines)))
		else $error("text RAM write beyond the last row");

endmodule

`default_nettype wire

// ==== logic/text_line_edit.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_line_edit import text_pkg::*; #(
	parameter int columns = 16
) (
	input wire mode, // 1 moves cells, 0 fills a range
	input wire [char_w-1:0] data,
	input wire [$clog2(columns+1)-1:0] col_start,
	input wire [$clog2(columns+1)-1:0] col_end,
	input wire [$clog2(columns+1)-1:0] col_now,
	input wire move_dir, // 1 walks right, 0 walks left
	input wire [columns*char_w-1:0] cur_line,
	output logic [columns*char_w-1:0] set_line,
	output logic [$clog2(columns+1)-1:0] next_col,
	output logic [$clog2(columns+1)-1:0] next_read_col
);

	localparam int cw = $clog2(columns + 1);

	logic [cw-1:0] stepped;
	logic [cw:0] span; // cells in the edited range
	logic [cw:0] src_ahead;

	assign span = {1'b0, col_end} - {1'b0, col_start} + 1'b1;
	assign stepped = move_dir ? col_now + 1'b1 : col_now - 1'b1;
	assign next_col = mode ? stepped : col_now;
	assign src_ahead = {1'b0, stepped} + span;

	always_comb
	begin
		if (!mode)
			next_read_col = cw'(columns);
		else if (move_dir)
		begin
			// deleting pulls the tail in from the right
			if (stepped < col_start)
				next_read_col = stepped;
			else if (src_ahead < (cw+1)'(columns))
				next_read_col = cw'(src_ahead);
			else
				next_read_col = cw'(columns); // past the end, blank enters
		end
		else
		begin
			// inserting pushes the tail to the right, walked from the end
			if (stepped > col_end)
				next_read_col = stepped - cw'(span);
			else if (stepped >= col_start)
				next_read_col = cw'(columns); // opened gap
			else
				next_read_col = stepped;
		end
	end

	for (genvar i = 0; i < columns; i++)
	begin : g_cell
		logic in_range;

		assign in_range = (cw'(i) >= col_start) && (cw'(i) <= col_end);
		assign set_line[i*char_w +: char_w] = in_range ? data
			: cur_line[i*char_w +: char_w];
	end

endmodule

`default_nettype wire

// ==== logic/text_pkg.sv ====
`default_nettype none

package text_pkg;

	// one screen cell, attribute in the high byte, character in the low byte
	localparam int char_w = 16;

	localparam logic [7:0] blank_attr = 8'h07;
	localparam logic [7:0] blank_char = 8'h20;

	// written by every erase, fill and scroll-in
	localparam logic [char_w-1:0] blank_cell = {blank_attr, blank_char};

	// editing commands as handed over by the upstream decoder
	typedef enum logic [3:0] {
		cmd_input,
		cmd_el,
		cmd_ech,
		cmd_ich,
		cmd_dch,
		cmd_ed,
		cmd_il,
		cmd_dl
	} cmd_e;

	// the one parameter byte of a command
	typedef union packed {
		logic [7:0] chr; // character code for INPUT
		logic [7:0] num; // count or mode for the other commands
	} cmd_param_u;

endpackage

`default_nettype wire

// ==== logic/text_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_ram import text_pkg::*; #(
	parameter int columns = 16,
	parameter int lines = 8
) (
	input wire clk,
	input wire [$clog2(lines)-1:0] addr,
	input wire wren,
	input wire [columns*char_w-1:0] wdata,
	output logic [columns*char_w-1:0] rdata,
	input wire [$clog2(lines)-1:0] disp_row,
	output logic [columns*char_w-1:0] disp_line
);

	// one word per screen row
	logic [columns*char_w-1:0] mem [lines];

	// edit port, read returns the old line on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (wren)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

	always_ff @(posedge clk)
	begin
		disp_line <= mem[disp_row]; // scan-out side
	end

	assert property (@(posedge clk) !$isunknown(wren))
		else $error("unknown write enable on the text RAM");

endmodule

`default_nettype wire

// ==== text_console.f ====
+incdir+verification
logic/text_pkg.sv
logic/text_line_edit.sv
logic/text_control.sv
logic/text_ram.sv
logic/text_console.sv
verification/text_console_tb.sv

// ==== verification/text_model.svh ====
`ifndef text_model_svh
`define text_model_svh

// reference screen, row then column
logic [char_w-1:0] screen [lines][columns];

function automatic int count_of(input logic [7:0] num);
	return (num == 8'd0) ? 1 : int'(num); // zero counts as one
endfunction

task automatic blank_cols(input int r, input int first, input int last);
	for (int c = first; c <= last; c++)
		screen[r][c] = blank_cell;
endtask

task automatic blank_rows(input int first, input int last);
	for (int r = first; r <= last; r++)
		blank_cols(r, 0, columns - 1);
endtask

task automatic copy_row(input int dst, input int src);
	for (int c = 0; c < columns; c++)
		screen[dst][c] = screen[src][c];
endtask

task automatic put_char(input int r, input int c, input logic [7:0] a, input logic [7:0] ch);
	logic [7:0] code;
	code = (ch == 8'h00) ? 8'h20 : ch;
	if (code >= 8'h20) // control codes leave the screen alone
		screen[r][c] = {a, code};
endtask

task automatic erase_line(input int r, input int c, input logic [7:0] mode);
	if (mode == 8'd0)
		blank_cols(r, c, columns - 1);
	else if (mode == 8'd1)
		blank_cols(r, 0, c);
	else
		blank_cols(r, 0, columns - 1);
endtask

task automatic erase_chars(input int r, input int c, input logic [7:0] num);
	int last;
	last = c + count_of(num) - 1;
	if (last > columns - 1)
		last = columns - 1; // clipped at the last column
	blank_cols(r, c, last);
endtask

task automatic insert_chars(input int r, input int c, input logic [7:0] num);
	int n;
	n = count_of(num);
	if (n > columns - c)
		n = columns - c;
	for (int i = columns - 1; i >= c + n; i--)
		screen[r][i] = screen[r][i - n];
	blank_cols(r, c, c + n - 1);
endtask

task automatic delete_chars(input int r, input int c, input logic [7:0] num);
	int n;
	n = count_of(num);
	if (n > columns - c)
		n = columns - c;
	for (int i = c; i < columns - n; i++)
		screen[r][i] = screen[r][i + n];
	blank_cols(r, columns - n, columns - 1); // blanks enter at the end
endtask

task automatic erase_display(input int r, input logic [7:0] mode);
	if (mode == 8'd0)
		blank_rows(r, lines - 1);
	else if (mode == 8'd1)
		blank_rows(0, r);
	else
		blank_rows(0, lines - 1);
endtask

task automatic insert_rows(input int r, input logic [7:0] num);
	int n;
	n = count_of(num);
	if (n > lines - r)
		n = lines - r;
	for (int i = lines - 1; i >= r + n; i--)
		copy_row(i, i - n);
	blank_rows(r, r + n - 1);
endtask

task automatic delete_rows(input int r, input logic [7:0] num);
	int n;
	n = count_of(num);
	if (n > lines - r)
		n = lines - r;
	for (int i = r; i < lines - n; i++)
		copy_row(i, i + n);
	blank_rows(lines - n, lines - 1);
endtask

`endif

// ==== verification/text_console_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_console_tb import text_pkg::*; ();

	localparam int columns = 16;
	localparam int lines = 8;
	localparam int rw = $clog2(lines);
	localparam int cw = $clog2(columns);
	localparam int fill_n = lines * columns;
	localparam int n_input = 40;
	localparam int n_erase = 12;
	localparam int n_shift = 20;
	localparam int n_scroll = 16;
	localparam int n_mix = 300;
	// six full-screen fills, plus the EL and ED mode passes
	localparam int n_commands = 1 + n_input + 6 * fill_n + 3 + n_erase
		+ n_shift + n_scroll + 3 + n_mix;
	localparam int cycle_limit = n_commands * (lines * columns * 4 + 64);

	logic clk = 1'b0;
	logic rst;
	logic cmd_valid;
	cmd_e cmd;
	cmd_param_u param;
	logic [rw-1:0] cur_row;
	logic [cw-1:0] cur_col;
	logic [7:0] attr;
	logic [rw-1:0] disp_row;
	logic busy;
	logic [columns*char_w-1:0] disp_line;

	logic [31:0] rng = 32'd6;
	int cycles = 0;

	`include "text_model.svh"

	text_console #(
		.columns(columns),
		.lines(lines)
	) DUT (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.param(param),
		.cur_row(cur_row),
		.cur_col(cur_col),
		.attr(attr),
		.disp_row(disp_row),
		.busy(busy),
		.disp_line(disp_line)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: the tests ran past %0d clock cycles", cycle_limit);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	task automatic pick_cursor(output int r, output int col);
		logic [31:0] v;
		v = xorshift();
		r = int'(v[15:0]) % lines;
		col = int'(v[31:16]) % columns;
	endtask

	// scan every row through the display port
	task automatic check_screen();
		logic [columns*char_w-1:0] want;
		for (int r = 0; r < lines; r++)
		begin
			disp_row = rw'(r);
			@(negedge clk); // one cycle of read latency
			for (int c = 0; c < columns; c++)
				want[c*char_w +: char_w] = screen[r][c];
			assert (disp_line == want)
			else
			begin
				$display("Error: disp_line row %0d is %h, expected %h", r, disp_line, want);
				$display("Done: errors found");
				$fatal(1);
			end
		end
	endtask

	task automatic issue(input cmd_e op, input logic [7:0] p, input int r, input int col,
		input logic [7:0] a);
		logic want_busy;
		@(negedge clk);
		cmd = op;
		if (op == cmd_input)
			param.chr = p;
		else
			param.num = p;
		cur_row = rw'(r);
		cur_col = cw'(col);
		attr = a;
		cmd_valid = 1'b1;
		want_busy = !(op == cmd_input && p != 8'h00 && p < 8'h20);
		@(negedge clk);
		cmd_valid = 1'b0;
		assert (busy == want_busy)
		else
		begin
			$display("Error: busy is %h, expected %h", busy, want_busy);
			$display("Done: errors found");
			$fatal(1);
		end
		while (busy)
			@(negedge clk);
		case (op)
		cmd_input:
			put_char(r, col, a, p);
		cmd_el:
			erase_line(r, col, p);
		cmd_ech:
			erase_chars(r, col, p);
		cmd_ich:
			insert_chars(r, col, p);
		cmd_dch:
			delete_chars(r, col, p);
		cmd_ed:
			erase_display(r, p);
		cmd_il:
			insert_rows(r, p);
		cmd_dl:
			delete_rows(r, p);
		default:
			;
		endcase
		check_screen();
	endtask

	// every cell gets its own character code
	task automatic fill_screen();
		logic [31:0] v;
		for (int r = 0; r < lines; r++)
			for (int c = 0; c < columns; c++)
			begin
				v = xorshift();
				issue(cmd_input, 8'(8'h21 + r * columns + c), r, c, v[7:0]);
			end
	endtask

	initial
	begin
		logic [31:0] v;
		logic [7:0] ch;
		int row;
		int col;

		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = cmd_input;
		param = '0;
		cur_row = '0;
		cur_col = '0;
		attr = '0;
		disp_row = '0;
		repeat (16)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		issue(cmd_ed, 8'd2, 0, 0, 8'h00); // RAM powers up unknown

		repeat (n_input)
		begin
			pick_cursor(row, col);
			v = xorshift();
			ch = v[7:0];
			if (v[10:8] == 3'd0)
				ch = v[7:0] & 8'h1f; // zero or a control code
			issue(cmd_input, ch, row, col, v[23:16]);
		end

		fill_screen();
		for (int m = 0; m < 3; m++)
		begin
			pick_cursor(row, col);
			v = xorshift();
			issue(cmd_el, (m < 2) ? 8'(m) : 8'h02 + {2'b00, v[5:0]}, row, col, v[15:8]);
		end
		repeat (n_erase)
		begin
			pick_cursor(row, col);
			v = xorshift();
			issue(cmd_ech, {3'b000, v[4:0]}, row, col, v[15:8]);
		end

		fill_screen();
		repeat (n_shift)
		begin
			pick_cursor(row, col);
			v = xorshift();
			if (v[0])
				issue(cmd_ich, {3'b000, v[8:4]}, row, col, v[23:16]);
			else
				issue(cmd_dch, {3'b000, v[8:4]}, row, col, v[23:16]);
		end

		fill_screen();
		repeat (n_scroll)
		begin
			pick_cursor(row, col);
			v = xorshift();
			if (v[0])
				issue(cmd_il, {4'h0, v[4:1]}, row, col, v[23:16]);
			else
				issue(cmd_dl, {4'h0, v[4:1]}, row, col, v[23:16]);
		end

		for (int m = 0; m < 3; m++)
		begin
			fill_screen();
			pick_cursor(row, col);
			v = xorshift();
			issue(cmd_ed, (m < 2) ? 8'(m) : 8'h02 + {2'b00, v[5:0]}, row, col, v[15:8]);
		end

		repeat (n_mix)
		begin
			pick_cursor(row, col);
			v = xorshift();
			if (v[19:16] >= 4'd8) // about half are typed characters
				issue(cmd_input, v[7:0], row, col, v[31:24]);
			else
				issue(cmd_e'(v[19:16]), {4'h0, v[11:8]}, row, col, v[31:24]);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
